// ==== sources.f ====
common/cache_pkg.sv
rtl/cache_req_port.sv
cache/cache_tag_array.sv
cache/cache_data_array.sv
cache/cache_ctrl.sv
rtl/cache_mem_master.sv
rtl/cache_top.sv
test/tb_cache.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module tb_cache -o tb_cache_sim &&
./obj_dir/tb_cache_sim | tee /dev/stderr | grep -F "All tests passed" > /dev/null &&
echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }

// ==== test/tb_cache.sv ====
// simulation top that drives CPU Wishbone requests into the data cache over a slow memory model
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
  import cache_pkg::*;

  localparam logic [31:0] SEED        = 32'hc601_3529;
  localparam int          MEM_WORDS   = 1024;  // 4 KB memory model
  localparam int          ACK_TIMEOUT = 2000;  // cycles per CPU access

  logic    clk;
  logic    rst;
  wb_m2s_t cpu_m2s;
  wb_s2m_t cpu_s2m;
  wb_m2s_t mem_m2s;
  wb_s2m_t mem_s2m;

  word_t      mem_words [MEM_WORDS];  // memory slave contents
  logic [7:0] ref_mem   [MEM_WORDS*4];  // byte image the CPU should see
  int         rd_count;
  int         wr_count;

  logic  exp_read;  // current request is a read
  word_t exp_word;
  addr_t exp_addr;
  int    errors;
  int    checks;
  int    cmp_errors;
  int    cmp_checks;
  int    tests;
  int    failed_tests;

  cache_top #(.NUM_SETS(16)) u_dut (
    .i_clk(clk),
    .i_rst(rst),
    .i_cpu(cpu_m2s),
    .o_cpu(cpu_s2m),
    .o_mem(mem_m2s),
    .i_mem(mem_s2m)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic word_t ref_read(input addr_t a);
    int base;
    base = int'(a[11:2]) * 4;
    return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
  endfunction

  task automatic ref_write(input addr_t a, input sel_t sel, input word_t d);
    int base;
    base = int'(a[11:2]) * 4;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) ref_mem[base+b] = d[8*b +: 8];
    end
  endtask

  function automatic int total_errors();
    return errors + cmp_errors;
  endfunction

  // --------------------------------------------------------------------------
  // memory slave with 0 to 3 wait states before each ack
  // --------------------------------------------------------------------------
  initial begin : mem_model
    logic [31:0] s;
    int          wait_left;
    logic        busy;
    logic [9:0]  wi;
    s = SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      s = lcg_next(s);
      mem_words[i] = s;
    end
    mem_s2m   = '0;
    busy      = 1'b0;
    wait_left = 0;
    rd_count  = 0;
    wr_count  = 0;
    forever begin
      @(negedge clk);
      if (rst || mem_s2m.ack) begin
        mem_s2m.ack = 1'b0;  // ack lasts one cycle
        busy        = 1'b0;
      end else if (mem_m2s.cyc && mem_m2s.stb) begin
        if (!busy) begin
          s         = lcg_next(s);
          wait_left = int'(s[31:30]);
          busy      = 1'b1;
        end
        if (wait_left > 0) begin
          wait_left--;
        end else begin
          wi = mem_m2s.adr[11:2];
          if (mem_m2s.we) begin
            for (int b = 0; b < 4; b++) begin
              if (mem_m2s.sel[b]) mem_words[wi][8*b +: 8] = mem_m2s.dat[8*b +: 8];
            end
            wr_count++;
          end else begin
            mem_s2m.dat = mem_words[wi];
            rd_count++;
          end
          mem_s2m.ack = 1'b1;
        end
      end
    end
  end

  // read data check on every CPU ack
  always @(negedge clk) begin
    if (!rst && cpu_s2m.ack && exp_read) begin
      cmp_checks++;
      if (cpu_s2m.dat !== exp_word) begin
        $display("CHECK FAILED at %0t: read %h returned %h, expected %h",
                 $time, exp_addr, cpu_s2m.dat, exp_word);
        cmp_errors++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // CPU side tasks
  // --------------------------------------------------------------------------
  task automatic cpu_access(input logic we, input addr_t a, input sel_t sel,
                            input word_t d, output int latency);
    int   n;
    logic seen;
    @(negedge clk);
    cpu_m2s.cyc = 1'b1;
    cpu_m2s.stb = 1'b1;
    cpu_m2s.we  = we;
    cpu_m2s.adr = a;
    cpu_m2s.sel = sel;
    cpu_m2s.dat = d;
    exp_addr    = a;
    exp_read    = !we;
    if (we) ref_write(a, sel, d);
    else exp_word = ref_read(a);
    n       = 0;
    seen    = 1'b0;
    latency = 0;
    while (!seen && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
      seen = cpu_s2m.ack;
    end
    if (!seen) begin
      $display("timeout at %0t: no CPU ack for address %h", $time, a);
      $display("Some tests failed");
      $finish;
    end else begin
      latency = n - 1;  // ack rose n-1 edges after the capture edge
      @(negedge clk);   // stb stays up through the edge that sees ack
      cpu_m2s = '0;
    end
  endtask

  task automatic write_then_read(input addr_t a, input sel_t sel, input word_t d);
    int lat;
    cpu_access(1'b1, a, sel, d, lat);
    cpu_access(1'b0, a, 4'hf, '0, lat);
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    tests++;
    if (total_errors() > err_before) begin
      failed_tests++;
      $display("test %0d %s: FAILED", num, name);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] s;
    int          lat;
    int          rd0;
    int          wr0;
    int          err0;
    int          st;
    int          t;
    int          w;
    addr_t       a;
    sel_t        sl;
    cpu_m2s      = '0;
    rst          = 1'b1;
    exp_read     = 1'b0;
    exp_word     = '0;
    exp_addr     = '0;
    errors       = 0;
    checks       = 0;
    cmp_errors   = 0;
    cmp_checks   = 0;
    tests        = 0;
    failed_tests = 0;
    s = SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin  // same sequence as the memory fill
      s = lcg_next(s);
      for (int b = 0; b < 4; b++) ref_mem[i*4+b] = s[8*b +: 8];
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // test 1 checks quiet buses after reset
    err0 = total_errors();
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      checks++;
      if (cpu_s2m.ack || mem_m2s.cyc) begin
        $display("CHECK FAILED at %0t: bus activity with no request", $time);
        errors++;
      end
    end
    report_test(1, "idle after reset", err0);

    // test 2 reads one word as a miss and then as a hit
    err0 = total_errors();
    a    = 32'h0000_0100;
    rd0  = rd_count;
    wr0  = wr_count;
    cpu_access(1'b0, a, 4'hf, '0, lat);
    checks++;
    if (rd_count - rd0 != 4 || wr_count != wr0) begin
      $display("CHECK FAILED at %0t: first read made %0d reads and %0d writes",
               $time, rd_count - rd0, wr_count - wr0);
      errors++;
    end
    rd0 = rd_count;
    wr0 = wr_count;
    cpu_access(1'b0, a, 4'hf, '0, lat);
    checks++;
    if (rd_count != rd0 || wr_count != wr0) begin
      $display("CHECK FAILED at %0t: hit made memory cycles", $time);
      errors++;
    end
    checks++;
    if (lat != 2) begin
      $display("CHECK FAILED at %0t: hit latency %0d, expected 2", $time, lat);
      errors++;
    end
    report_test(2, "read miss then hit", err0);

    // test 3 merges byte lanes into one word
    err0 = total_errors();
    a    = 32'h0000_0214;
    write_then_read(a, 4'b0001, 32'ha1a2_a3a4);
    write_then_read(a, 4'b0100, 32'hb1b2_b3b4);
    write_then_read(a, 4'b0011, 32'hc1c2_c3c4);  // low half-word
    write_then_read(a, 4'b1100, 32'hd1d2_d3d4);
    write_then_read(a, 4'b1111, 32'h0bad_f00d);
    write_then_read(a, 4'b0010, 32'he1e2_e3e4);
    report_test(3, "byte enable writes", err0);

    // test 4 puts three lines into set 3
    err0 = total_errors();
    cpu_access(1'b0, 32'h0000_0330, 4'hf, '0, lat);  // A
    cpu_access(1'b0, 32'h0000_0430, 4'hf, '0, lat);  // B
    cpu_access(1'b1, 32'h0000_0334, 4'hf, 32'h1357_9bdf, lat);
    cpu_access(1'b1, 32'h0000_0338, 4'b0010, 32'h0000_5a00, lat);
    rd0 = rd_count;
    wr0 = wr_count;
    cpu_access(1'b0, 32'h0000_0530, 4'hf, '0, lat);  // C evicts clean B
    checks++;
    if (rd_count - rd0 != 4 || wr_count != wr0) begin
      $display("CHECK FAILED at %0t: evicting B made %0d reads and %0d writes",
               $time, rd_count - rd0, wr_count - wr0);
      errors++;
    end
    rd0 = rd_count;
    wr0 = wr_count;
    cpu_access(1'b0, 32'h0000_0430, 4'hf, '0, lat);  // B evicts dirty A
    checks++;
    if (rd_count - rd0 != 4 || wr_count - wr0 != 4) begin
      $display("CHECK FAILED at %0t: evicting A made %0d reads and %0d writes",
               $time, rd_count - rd0, wr_count - wr0);
      errors++;
    end
    for (int i = 0; i < 4; i++) begin
      a = 32'h0000_0330 + addr_t'(4 * i);
      checks++;
      if (mem_words[int'(a[11:2])] !== ref_read(a)) begin
        $display("CHECK FAILED at %0t: memory at %h holds %h, expected %h",
                 $time, a, mem_words[int'(a[11:2])], ref_read(a));
        errors++;
      end
    end
    report_test(4, "set conflicts and write-back", err0);

    // test 5 runs a random mix over 3 lines in each of sets 8 to 11
    err0 = total_errors();
    for (int i = 0; i < 200; i++) begin
      s  = lcg_next(s);
      st = int'(s[31:30]);
      w  = int'(s[29:28]);
      t  = int'(s[22:16]) % 3;
      sl = (s[26:23] == 4'h0) ? 4'hf : s[26:23];
      a  = addr_t'((8 + t) * 256 + (8 + st) * 16 + w * 4);
      if (s[27]) begin
        s = lcg_next(s);
        cpu_access(1'b1, a, sl, s, lat);
      end else begin
        cpu_access(1'b0, a, 4'hf, '0, lat);
      end
    end
    for (st = 0; st < 4; st++) begin  // read back the whole footprint
      for (t = 0; t < 3; t++) begin
        for (w = 0; w < 4; w++) begin
          a = addr_t'((8 + t) * 256 + (8 + st) * 16 + w * 4);
          cpu_access(1'b0, a, 4'hf, '0, lat);
        end
      end
    end
    report_test(5, "random mix", err0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks + cmp_checks, total_errors());
    if (total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
// top of the two-way write-back data cache, joins the CPU port, the arrays, the FSM and memory master
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = cache_pkg::ADDR_W - IDX_W - cache_pkg::OFF_W - 2
) (
  input  wire                i_clk,
  input  wire                i_rst,
  input  cache_pkg::wb_m2s_t i_cpu,
  output cache_pkg::wb_s2m_t o_cpu,
  output cache_pkg::wb_m2s_t o_mem,
  input  cache_pkg::wb_s2m_t i_mem
);
  import cache_pkg::*;

  // --------------------------------------------------------------------------
  // interconnect
  // --------------------------------------------------------------------------
  logic             start, done;
  cpu_req_t         req;
  word_t            ctrl_rdata, dat_rdata, dat_wdata, fill_data;
  logic [IDX_W-1:0] index;
  logic [TAG_W-1:0] tag, victim_tag;
  logic             hit, hit_way, victim_way, victim_dirty;
  logic             tag_fill_we, tag_fill_way, touch, touch_way, set_dirty;
  logic             dat_way, dat_we;
  sel_t             dat_sel;
  logic [OFF_W-1:0] dat_word, word_idx;
  logic             cmd_valid, cmd_done, fill_we;
  mem_cmd_t         cmd;

  cache_req_port u_req_port (
    .i_clk(i_clk), .i_rst(i_rst), .i_cpu(i_cpu), .o_cpu(o_cpu),
    .o_start(start), .o_req(req), .i_done(done), .i_rdata(ctrl_rdata)
  );

  cache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(start), .i_req(req),
    .o_done(done), .o_rdata(ctrl_rdata), .o_index(index), .o_tag(tag),
    .i_hit(hit), .i_hit_way(hit_way), .i_victim_way(victim_way),
    .i_victim_dirty(victim_dirty), .i_victim_tag(victim_tag),
    .o_tag_fill_we(tag_fill_we), .o_tag_fill_way(tag_fill_way),
    .o_touch(touch), .o_touch_way(touch_way), .o_set_dirty(set_dirty),
    .o_dat_way(dat_way), .o_dat_we(dat_we), .o_dat_sel(dat_sel),
    .o_dat_wdata(dat_wdata), .i_dat_rdata(dat_rdata), .o_wb_word_sel(dat_word),
    .o_cmd_valid(cmd_valid), .o_cmd(cmd), .i_cmd_done(cmd_done),
    .i_fill_we(fill_we), .i_fill_word(word_idx), .i_fill_data(fill_data)
  );

  cache_tag_array #(.NUM_SETS(NUM_SETS)) u_tag_array (
    .i_clk(i_clk), .i_rst(i_rst), .i_index(index), .i_tag(tag),
    .o_hit_way(hit_way), .o_hit(hit), .o_victim_way(victim_way),
    .o_victim_dirty(victim_dirty), .o_victim_tag(victim_tag),
    .i_fill_we(tag_fill_we), .i_fill_way(tag_fill_way),
    .i_touch(touch), .i_touch_way(touch_way), .i_set_dirty(set_dirty)
  );

  cache_data_array #(.NUM_SETS(NUM_SETS)) u_data_array (
    .i_clk(i_clk), .i_index(index), .i_way(dat_way), .i_word(dat_word),
    .o_rdata(dat_rdata), .i_we(dat_we), .i_sel(dat_sel), .i_wdata(dat_wdata)
  );

  cache_mem_master u_mem_master (
    .i_clk(i_clk), .i_rst(i_rst), .i_cmd_valid(cmd_valid), .i_cmd(cmd),
    .o_cmd_done(cmd_done), .o_mem(o_mem), .i_mem(i_mem),
    .o_word_idx(word_idx), .i_wb_data(dat_rdata),
    .o_fill_we(fill_we), .o_fill_data(fill_data)
  );

endmodule

`default_nettype wire

// ==== rtl/cache_mem_master.sv ====
// memory-side Wishbone master, moves one four-word line per command in single classic cycles
`timescale 1ns/1ps
`default_nettype none

module cache_mem_master (
  input  wire                         i_clk,
  input  wire                         i_rst,
  input  wire                         i_cmd_valid,
  input  cache_pkg::mem_cmd_t         i_cmd,
  output logic                        o_cmd_done,
  output cache_pkg::wb_m2s_t          o_mem,
  input  cache_pkg::wb_s2m_t          i_mem,
  output logic [cache_pkg::OFF_W-1:0] o_word_idx,
  input  cache_pkg::word_t            i_wb_data,
  output logic                        o_fill_we,
  output cache_pkg::word_t            o_fill_data
);
  import cache_pkg::*;

  localparam logic [OFF_W-1:0] LAST_WORD = OFF_W'(WORDS_PER_LINE - 1);

  logic             busy_q;
  logic [OFF_W-1:0] idx_q;
  mem_cmd_t         cmd_q;
  logic             last_ack;

  assign last_ack = busy_q && i_mem.ack && (idx_q == LAST_WORD);

  // --------------------------------------------------------------------------
  // word sequencing, a stall simply holds idx_q
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      if (!busy_q && i_cmd_valid) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else if (busy_q && i_mem.ack) begin
        idx_q <= idx_q + 1'b1;  // next transfer starts right away
        if (last_ack) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!busy_q && i_cmd_valid) begin
      cmd_q <= i_cmd;
    end
  end

  assign o_mem.cyc = busy_q;
  assign o_mem.stb = busy_q;
  assign o_mem.we  = cmd_q.we;
  assign o_mem.adr = {cmd_q.line_addr[ADDR_W-1:OFF_W+2], idx_q, 2'b00};
  assign o_mem.sel = '1;
  assign o_mem.dat = i_wb_data;  // victim word at o_word_idx

  assign o_word_idx  = idx_q;
  assign o_fill_we   = busy_q && !cmd_q.we && i_mem.ack;
  assign o_fill_data = i_mem.dat;
  assign o_cmd_done  = last_ack;

endmodule

`default_nettype wire

// ==== cache/cache_ctrl.sv ====
// main cache FSM, runs lookup, dirty victim write-back, refill and store merge per request
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = cache_pkg::ADDR_W - IDX_W - cache_pkg::OFF_W - 2
) (
  input  wire                         i_clk,
  input  wire                         i_rst,
  input  wire                         i_start,
  input  cache_pkg::cpu_req_t         i_req,
  output logic                        o_done,
  output cache_pkg::word_t            o_rdata,
  // tag array
  output logic [IDX_W-1:0]            o_index,
  output logic [TAG_W-1:0]            o_tag,
  input  wire                         i_hit,
  input  wire                         i_hit_way,
  input  wire                         i_victim_way,
  input  wire                         i_victim_dirty,
  input  wire  [TAG_W-1:0]            i_victim_tag,
  output logic                        o_tag_fill_we,
  output logic                        o_tag_fill_way,
  output logic                        o_touch,
  output logic                        o_touch_way,
  output logic                        o_set_dirty,
  // data array
  output logic                        o_dat_way,
  output logic                        o_dat_we,
  output cache_pkg::sel_t             o_dat_sel,
  output cache_pkg::word_t            o_dat_wdata,
  input  cache_pkg::word_t            i_dat_rdata,
  output logic [cache_pkg::OFF_W-1:0] o_wb_word_sel,  // data array word index
  // memory master
  output logic                        o_cmd_valid,
  output cache_pkg::mem_cmd_t         o_cmd,
  input  wire                         i_cmd_done,
  input  wire                         i_fill_we,
  input  wire  [cache_pkg::OFF_W-1:0] i_fill_word,  // also the write-back word
  input  cache_pkg::word_t            i_fill_data
);
  import cache_pkg::*;

  localparam int LINE_LSB = OFF_W + 2;

  ctrl_state_e state_q;
  logic        vic_way_q;  // frozen at the miss
  logic        lookup_hit;
  addr_t       req_line;

  assign o_index    = i_req.addr[LINE_LSB +: IDX_W];
  assign o_tag      = i_req.addr[ADDR_W-1 -: TAG_W];
  assign req_line   = {i_req.addr[ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
  assign lookup_hit = (state_q == S_LOOKUP) && i_hit;

  // --------------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q     <= S_IDLE;
      o_cmd_valid <= 1'b0;
    end else begin
      o_cmd_valid <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (i_start) state_q <= S_LOOKUP;
        end
        S_LOOKUP: begin
          if (i_hit) begin
            state_q <= S_IDLE;
          end else begin
            o_cmd_valid <= 1'b1;
            state_q     <= i_victim_dirty ? S_WBACK : S_REFILL;
          end
        end
        S_WBACK: begin
          if (i_cmd_done) begin
            o_cmd_valid <= 1'b1;  // refill right after the write-back
            state_q     <= S_REFILL;
          end
        end
        S_REFILL: begin
          if (i_cmd_done) state_q <= S_MERGE;
        end
        S_MERGE: state_q <= S_DONE;
        S_DONE:  state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // command and victim payload
  always_ff @(posedge i_clk) begin
    if (state_q == S_LOOKUP && !i_hit) begin
      vic_way_q       <= i_victim_way;
      o_cmd.we        <= i_victim_dirty;
      o_cmd.line_addr <= i_victim_dirty ? {i_victim_tag, o_index, {LINE_LSB{1'b0}}} : req_line;
    end else if (state_q == S_WBACK && i_cmd_done) begin
      o_cmd.we        <= 1'b0;
      o_cmd.line_addr <= req_line;
    end
  end

  // --------------------------------------------------------------------------
  // array controls
  // --------------------------------------------------------------------------
  always_comb begin
    o_dat_way     = vic_way_q;
    o_wb_word_sel = i_req.addr[2 +: OFF_W];
    o_dat_we      = 1'b0;
    o_dat_sel     = i_req.sel;
    o_dat_wdata   = i_req.wdata;
    case (state_q)
      S_LOOKUP: begin
        o_dat_way = i_hit_way;
        o_dat_we  = i_hit && i_req.we;  // store hit
      end
      S_WBACK: o_wb_word_sel = i_fill_word;  // follows the memory master
      S_REFILL: begin
        o_wb_word_sel = i_fill_word;
        o_dat_we      = i_fill_we;
        o_dat_sel     = '1;
        o_dat_wdata   = i_fill_data;
      end
      S_MERGE: o_dat_we = i_req.we;  // pending store into the new line
      default: ;
    endcase
  end

  assign o_tag_fill_we  = (state_q == S_REFILL) && i_cmd_done;
  assign o_tag_fill_way = vic_way_q;
  assign o_touch        = lookup_hit || (state_q == S_MERGE);
  assign o_touch_way    = (state_q == S_LOOKUP) ? i_hit_way : vic_way_q;
  assign o_set_dirty    = i_req.we;

  assign o_done  = lookup_hit || (state_q == S_DONE);
  assign o_rdata = i_dat_rdata;

endmodule

`default_nettype wire

// ==== cache/cache_data_array.sv ====
// line storage for both ways, byte-masked word writes and combinational word read
`timescale 1ns/1ps
`default_nettype none

module cache_data_array #(
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS)
) (
  input  wire                             i_clk,
  input  wire  [IDX_W-1:0]                i_index,
  input  wire                             i_way,
  input  wire  [cache_pkg::OFF_W-1:0]     i_word,
  output cache_pkg::word_t                o_rdata,
  input  wire                             i_we,
  input  cache_pkg::sel_t                 i_sel,
  input  cache_pkg::word_t                i_wdata
);
  import cache_pkg::*;

  localparam int DEPTH = NUM_WAYS * NUM_SETS * WORDS_PER_LINE;

  word_t                 mem_q [DEPTH];
  logic  [IDX_W+OFF_W:0] addr;  // {way, set, word}

  assign addr = {i_way, i_index, i_word};

  // refill drives all four enables
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (i_sel[b]) begin
          mem_q[addr][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  assign o_rdata = mem_q[addr];  // word select from the line

endmodule

`default_nettype wire

// ==== cache/cache_tag_array.sv ====
// valid, dirty and tag storage for both ways with hit compare, LRU and victim choice
`timescale 1ns/1ps
`default_nettype none

module cache_tag_array #(
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = cache_pkg::ADDR_W - IDX_W - cache_pkg::OFF_W - 2
) (
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire  [IDX_W-1:0] i_index,
  input  wire  [TAG_W-1:0] i_tag,
  output logic             o_hit_way,
  output logic             o_hit,
  output logic             o_victim_way,
  output logic             o_victim_dirty,
  output logic [TAG_W-1:0] o_victim_tag,
  input  wire              i_fill_we,
  input  wire              i_fill_way,
  input  wire              i_touch,
  input  wire              i_touch_way,
  input  wire              i_set_dirty
);
  import cache_pkg::*;

  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
  logic [NUM_SETS-1:0] lru_q;                   // least recently used way per set
  logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] way_hit;

  // --------------------------------------------------------------------------
  // compare both ways at once
  // --------------------------------------------------------------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = valid_q[i_index][w] && (tag_q[i_index][w] == i_tag);
    end
  end

  assign o_hit     = |way_hit;
  assign o_hit_way = way_hit[1];

  // invalid way first, else the LRU one
  assign o_victim_way   = !valid_q[i_index][0] ? 1'b0 :
                          !valid_q[i_index][1] ? 1'b1 : lru_q[i_index];
  assign o_victim_dirty = valid_q[i_index][o_victim_way] && dirty_q[i_index][o_victim_way];
  assign o_victim_tag   = tag_q[i_index][o_victim_way];

  // --------------------------------------------------------------------------
  // state bits
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      lru_q <= '0;
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else begin
      if (i_fill_we) begin
        valid_q[i_index][i_fill_way] <= 1'b1;
        dirty_q[i_index][i_fill_way] <= 1'b0;  // clean after refill
      end
      if (i_touch) begin
        lru_q[i_index] <= ~i_touch_way;       // other way becomes LRU
        if (i_set_dirty) begin
          dirty_q[i_index][i_touch_way] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_we) begin
      tag_q[i_index][i_fill_way] <= i_tag;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cache_req_port.sv ====
// CPU-side Wishbone slave, captures one request at a time and returns its ack and read word
`timescale 1ns/1ps
`default_nettype none

module cache_req_port (
  input  wire                 i_clk,
  input  wire                 i_rst,
  input  cache_pkg::wb_m2s_t  i_cpu,
  output cache_pkg::wb_s2m_t  o_cpu,
  output logic                o_start,
  output cache_pkg::cpu_req_t o_req,
  input  wire                 i_done,
  input  cache_pkg::word_t    i_rdata
);
  import cache_pkg::*;

  logic     busy_q;
  logic     ack_q;
  word_t    rdata_q;
  cpu_req_t req_q;
  logic     capture;

  // no capture while the ack of the last request is still on the bus
  assign capture = i_cpu.cyc && i_cpu.stb && !busy_q && !ack_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q  <= 1'b0;
      ack_q   <= 1'b0;
      o_start <= 1'b0;
    end else begin
      o_start <= capture;  // one-cycle pulse
      ack_q   <= i_done;
      if (capture) begin
        busy_q <= 1'b1;
      end
      if (i_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // payload registers
  always_ff @(posedge i_clk) begin
    if (capture) begin
      req_q.we    <= i_cpu.we;
      req_q.addr  <= i_cpu.adr;
      req_q.sel   <= i_cpu.sel;
      req_q.wdata <= i_cpu.dat;
    end
    if (i_done) begin
      rdata_q <= i_rdata;
    end
  end

  assign o_req     = req_q;
  assign o_cpu.ack = ack_q;
  assign o_cpu.dat = rdata_q;

endmodule

`default_nettype wire

// ==== common/cache_pkg.sv ====
// shared widths, bus bundles and controller states for the data cache, imported by every block
`default_nettype none

package cache_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  localparam int ADDR_W         = 32;  // byte address
  localparam int DATA_W         = 32;  // word
  localparam int SEL_W          = 4;   // byte enables per word
  localparam int WORDS_PER_LINE = 4;
  localparam int OFF_W          = 2;   // word offset within a line
  localparam int NUM_WAYS       = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [SEL_W-1:0]  sel_t;

  // --------------------------------------------------------------------------
  // bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic  we;
    addr_t addr;
    sel_t  sel;
    word_t wdata;
  } cpu_req_t;  // request buffer

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    sel_t  sel;
    word_t dat;
  } wb_m2s_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_s2m_t;

  typedef struct packed {
    logic  we;         // 1 write-back, 0 refill
    addr_t line_addr;  // low four bits zero
  } mem_cmd_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_WBACK,
    S_REFILL,
    S_MERGE,
    S_DONE
  } ctrl_state_e;

endpackage

`default_nettype wire
